// File: logic/axil_reg_ctrl.sv
// AXI4-Lite slave front end; holds the control word, decodes reads and strobes status reads
`timescale 1ns/1ns

module axil_reg_ctrl import s2p_pkg::*; (
    input  logic           s_axi_aclk,
    input  logic           s_axi_aresetn,

    input  logic [31:0]    s_axi_awaddr,
    input  logic           s_axi_awvalid,
    output logic           s_axi_awready,

    input  logic [31:0]    s_axi_wdata,
    input  logic [3:0]     s_axi_wstrb,
    input  logic           s_axi_wvalid,
    output logic           s_axi_wready,

    output logic [1:0]     s_axi_bresp,
    output logic           s_axi_bvalid,
    input  logic           s_axi_bready,

    input  logic [31:0]    s_axi_araddr,
    input  logic           s_axi_arvalid,
    output logic           s_axi_arready,

    output logic [31:0]    s_axi_rdata,
    output logic [1:0]     s_axi_rresp,
    output logic           s_axi_rvalid,
    input  logic           s_axi_rready,

    input  status_fields_t status,
    output ctrl_fields_t   ctrl,
    output logic           status_rd
);

    // Write path state
    logic        wr_busy;     // One write in flight until bready
    logic        wr_apply;    // Handshake done, commit next edge
    logic [7:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        wr_accept;
    logic        wr_hs;

    // Read path state
    logic        rd_busy;
    logic        rd_apply;
    logic [7:0]  rd_addr;
    logic        rd_accept;
    logic        rd_hs;
    logic [31:0] rd_word;

    ctrl_word_u  ctrl_q;
    ctrl_word_u  ctrl_next;
    ctrl_word_u  ctrl_rd;

    assign wr_accept = s_axi_awvalid && s_axi_wvalid && !wr_busy;
    assign wr_hs     = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;
    assign rd_accept = s_axi_arvalid && !rd_busy;
    assign rd_hs     = s_axi_arready && s_axi_arvalid;

    // Next control word with lane merge on a matching write and flush dropped
    always_comb begin
        ctrl_next = ctrl_q;
        ctrl_next.fields.flush = 1'b0;
        if (wr_apply && (wr_addr == ctrl_addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    ctrl_next.raw[8*i +: 8] = wr_data[8*i +: 8];
                end
            end
        end
    end

    assign ctrl = ctrl_q.fields;

    // Write channels; accept at one edge, handshake at the next, commit after that
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= 2'b00;
            wr_busy       <= 1'b0;
            wr_apply      <= 1'b0;
            wr_addr       <= 8'h00;
            wr_data       <= 32'h0;
            wr_strb       <= 4'h0;
            ctrl_q.raw    <= 32'h0;
        end else begin
            s_axi_awready <= wr_accept;  // Single-cycle pulses
            s_axi_wready  <= wr_accept;
            wr_apply      <= wr_hs;
            ctrl_q        <= ctrl_next;

            if (wr_accept) begin
                wr_busy <= 1'b1;
            end else if (s_axi_bvalid && s_axi_bready) begin
                wr_busy <= 1'b0;
            end

            if (wr_hs) begin
                wr_addr <= s_axi_awaddr[7:0];
                wr_data <= s_axi_wdata;
                wr_strb <= s_axi_wstrb;
            end

            if (wr_apply) begin
                s_axi_bvalid <= 1'b1;  // Same edge as the register update
                s_axi_bresp  <= axi_okay;
            end else if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    // Read mux; flush never reads back as set
    always_comb begin
        ctrl_rd = ctrl_q;
        ctrl_rd.fields.flush = 1'b0;
        case (rd_addr)
            ctrl_addr:   rd_word = ctrl_rd.raw;
            status_addr: rd_word = status;
            default:     rd_word = 32'h0;
        endcase
    end

    // Clears new_byte at the edge where rdata samples status
    assign status_rd = rd_apply && (rd_addr == status_addr);

    // Read channels
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rresp   <= 2'b00;
            s_axi_rdata   <= 32'h0;
            rd_busy       <= 1'b0;
            rd_apply      <= 1'b0;
            rd_addr       <= 8'h00;
        end else begin
            s_axi_arready <= rd_accept;
            rd_apply      <= rd_hs;

            if (rd_accept) begin
                rd_busy <= 1'b1;
            end else if (s_axi_rvalid && s_axi_rready) begin
                rd_busy <= 1'b0;
            end

            if (rd_hs) begin
                rd_addr <= s_axi_araddr[7:0];
            end

            if (rd_apply) begin
                s_axi_rvalid <= 1'b1;
                s_axi_rresp  <= axi_okay;
                s_axi_rdata  <= rd_word;
            end else if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: logic/s2p_deserializer.sv
// Three-stage bit sampler and byte assembler; emits one beat strobe per completed byte
`timescale 1ns/1ns

module s2p_deserializer import s2p_pkg::*; (
    input  logic         s_axi_aclk,
    input  logic         s_axi_aresetn,
    input  logic         serial_in,
    input  ctrl_fields_t ctrl,
    output byte_beat_t   beat
);

    logic [2:0] pos;       // Next bit position
    logic       s1_valid;
    logic       s1_bit;
    logic       s1_msb;
    logic [2:0] s1_pos;
    logic [7:0] partial;   // Byte under assembly
    logic       s2_valid;
    logic [7:0] s2_byte;
    logic [2:0] slot;
    logic [7:0] merged;

    // Bit slot from position and order
    always_comb begin
        slot = s1_msb ? (3'd7 - s1_pos) : s1_pos;
        merged = partial;
        merged[slot] = s1_bit;
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            pos        <= 3'd0;
            s1_valid   <= 1'b0;
            s1_bit     <= 1'b0;
            s1_msb     <= 1'b0;
            s1_pos     <= 3'd0;
            partial    <= 8'h00;
            s2_valid   <= 1'b0;
            s2_byte    <= 8'h00;
            beat.valid <= 1'b0;
            beat.data  <= 8'h00;
        end else begin
            // Stage 3 forwards completed bytes, even across a flush
            beat.valid <= s2_valid;
            beat.data  <= s2_byte;

            if (ctrl.flush) begin
                pos      <= 3'd0;   // Bits still in stage 1 are dropped
                s1_valid <= 1'b0;
                partial  <= 8'h00;
                s2_valid <= 1'b0;
            end else begin
                // Stage 1
                s1_valid <= ctrl.enable;
                s1_bit   <= serial_in;
                s1_msb   <= ctrl.msb_first;
                s1_pos   <= pos;
                if (ctrl.enable) begin
                    pos <= pos + 3'd1;  // Wraps after the eighth bit
                end

                // Stage 2
                s2_valid <= s1_valid && (s1_pos == 3'd7);
                if (s1_valid) begin
                    partial <= merged;
                    if (s1_pos == 3'd7) begin
                        s2_byte <= merged;
                    end
                end
            end
        end
    end

endmodule

// File: logic/s2p_pkg.sv
// Shared register offsets, field layouts and handshake types for the serial-to-parallel core
package s2p_pkg;

    // Register byte offsets matched on the low 8 address bits
    localparam logic [7:0] ctrl_addr   = 8'h00;
    localparam logic [7:0] status_addr = 8'h04;

    localparam logic [1:0] axi_okay = 2'b00;  // Every access answers OKAY

    // Control register layout
    typedef struct packed {
        logic [28:0] reserved;
        logic        flush;      // Self-clearing, reads back 0
        logic        msb_first;  // 1 places bit 7 first
        logic        enable;
    } ctrl_fields_t;

    // Written lane-wise as raw, decoded as fields
    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t fields;
    } ctrl_word_u;

    // Status register layout
    typedef struct packed {
        logic [15:0] byte_count;  // Wraps at 65535
        logic [6:0]  reserved;
        logic        new_byte;    // Sticky until a status read
        logic [7:0]  last_byte;
    } status_fields_t;

    // One completed byte from the deserializer
    typedef struct packed {
        logic       valid;  // Single-cycle strobe
        logic [7:0] data;
    } byte_beat_t;

endpackage

// File: logic/s2p_status_collector.sv
// Status register builder; last byte, sticky new-byte flag and completed-byte count
`timescale 1ns/1ns

module s2p_status_collector import s2p_pkg::*; (
    input  logic           s_axi_aclk,
    input  logic           s_axi_aresetn,
    input  byte_beat_t     beat,
    input  logic           status_rd,
    output status_fields_t status
);

    logic [7:0]  last_byte;
    logic        new_byte;
    logic [15:0] byte_count;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            last_byte  <= 8'h00;
            new_byte   <= 1'b0;
            byte_count <= 16'h0000;
        end else begin
            if (beat.valid) begin
                last_byte  <= beat.data;
                new_byte   <= 1'b1;   // A beat wins over a read in the same cycle
                byte_count <= byte_count + 16'd1;
            end else if (status_rd) begin
                new_byte <= 1'b0;
            end
        end
    end

    // Reserved bits read as zero
    always_comb begin
        status.byte_count = byte_count;
        status.reserved   = 7'd0;
        status.new_byte   = new_byte;
        status.last_byte  = last_byte;
    end

endmodule

// File: logic/s2p_top.sv
// Top level of the AXI4-Lite serial-to-parallel peripheral; connects front end and datapath
`timescale 1ns/1ns

module s2p_top import s2p_pkg::*; (
    input  logic        s_axi_aclk,
    input  logic        s_axi_aresetn,
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    input  logic        serial_in      // Synchronous to s_axi_aclk
);

    ctrl_fields_t   ctrl;
    status_fields_t status;
    logic           status_rd;
    byte_beat_t     beat;

    axil_reg_ctrl u_reg_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .status        (status),
        .ctrl          (ctrl),
        .status_rd     (status_rd)
    );

    s2p_deserializer u_deserializer (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .serial_in     (serial_in),
        .ctrl          (ctrl),
        .beat          (beat)
    );

    s2p_status_collector u_status (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .beat          (beat),
        .status_rd     (status_rd),
        .status        (status)
    );

endmodule

// File: project.f
+incdir+tb
logic/s2p_pkg.sv
logic/axil_reg_ctrl.sv
logic/s2p_deserializer.sv
logic/s2p_status_collector.sv
logic/s2p_top.sv
tb/tb_s2p.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f project.f --top-module tb_s2p
out=$(./obj_dir/Vtb_s2p)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'STATUS: PASS'

// File: tb/tb_axil_tasks.svh
// AXI4-Lite master write and read tasks with per-wait timeouts; included inside the testbench

task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [31:0] mask;
    int n;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    pend_raw = mirror_raw;  // Lane merge only for the control register
    if (addr[7:0] == ctrl_addr) begin
        pend_raw = (mirror_raw & ~mask) | (data & mask);
    end
    pend_flush  = pend_raw[2];
    pend_raw[2] = 1'b0;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    n = 0;
    do begin
        @(negedge s_axi_aclk);
        n++;
    end while (!(s_axi_awready && s_axi_wready) && n < 40);
    if (!(s_axi_awready && s_axi_wready)) begin
        report_timeout("awready and wready");
        return;
    end
    @(negedge s_axi_aclk);  // Handshake at the edge in between
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    while (!s_axi_bvalid && n < 40) begin
        @(negedge s_axi_aclk);
        n++;
    end
    if (!s_axi_bvalid) begin
        report_timeout("bvalid");
        return;
    end
    check_value("bresp", 32'(s_axi_bresp), 32'(axi_okay));
    repeat (pick_below(bp_max + 1)) @(negedge s_axi_aclk);
    s_axi_bready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    data = 32'h0;
    rd_status_pend = (addr[7:0] == status_addr);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    do begin
        @(negedge s_axi_aclk);
        n++;
    end while (!s_axi_arready && n < 40);
    if (!s_axi_arready) begin
        report_timeout("arready");
        return;
    end
    @(negedge s_axi_aclk);
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid && n < 40) begin
        @(negedge s_axi_aclk);
        n++;
    end
    if (!s_axi_rvalid) begin
        report_timeout("rvalid");
        return;
    end
    data = s_axi_rdata;  // Held while rvalid waits for rready
    check_value("rresp", 32'(s_axi_rresp), 32'(axi_okay));
    repeat (pick_below(bp_max + 1)) @(negedge s_axi_aclk);
    s_axi_rready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_rready = 1'b0;
endtask

// File: tb/tb_s2p.sv
// Testbench for the serial-to-parallel peripheral; random serial stream checked against a model
`timescale 1ns/1ns

module tb_s2p import s2p_pkg::*; ();

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        serial_in = 1'b0;

    int seed = 98778;       // Serial stream
    int stim_seed = 98778;  // Test parameters and stalls
    int bp_max;             // Longest bready or rready stall
    int err_count;
    int test_errs;
    int pass_count;
    int fail_count;
    logic hung;

    // Model state
    logic [31:0] mirror_raw;   // Control word as software should read it
    logic [31:0] pend_raw;     // Committed when bvalid rises
    logic        pend_flush;
    logic        rd_status_pend;
    logic        commit;
    logic        skip_next;
    logic [2:0]  bit_pos;
    logic [2:0]  slot;
    logic [7:0]  part;
    logic [7:0]  exp_last;
    logic [15:0] exp_count;
    logic        exp_new;
    logic        prev_bvalid;
    logic        prev_rvalid;
    logic [31:0] serial_rnd;

    s2p_top DUT (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #4 s_axi_aclk = ~s_axi_aclk;
    end

    // Model and serial stimulus on the falling edge
    always @(negedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            mirror_raw  = 32'h0;
            skip_next   = 1'b0;
            bit_pos     = 3'd0;
            part        = 8'h00;
            exp_last    = 8'h00;
            exp_count   = 16'h0;
            exp_new     = 1'b0;
            prev_bvalid = 1'b0;
            prev_rvalid = 1'b0;
        end else begin
            commit = s_axi_bvalid && !prev_bvalid;
            // A flush drops the bits sampled at its commit edge and the one after
            if (mirror_raw[0] && !skip_next && !(commit && pend_flush)) begin
                slot = mirror_raw[1] ? 3'd7 - bit_pos : bit_pos;
                part[slot] = serial_in;
                if (bit_pos == 3'd7) begin
                    exp_last  = part;
                    exp_count = exp_count + 16'd1;
                    exp_new   = 1'b1;
                end
                bit_pos = bit_pos + 3'd1;
            end
            skip_next = commit && pend_flush;
            if (commit) begin
                mirror_raw = pend_raw;
                if (pend_flush) begin
                    bit_pos = 3'd0;
                    part    = 8'h00;
                end
            end
            if (s_axi_rvalid && !prev_rvalid && rd_status_pend) begin
                exp_new = 1'b0;  // Cleared by our own status read
            end
            prev_bvalid = s_axi_bvalid;
            prev_rvalid = s_axi_rvalid;
        end
        serial_rnd = $random(seed);
        serial_in  = serial_rnd[0];
    end

    function automatic int pick_below(input int limit);
        logic [31:0] r;
        r = $random(stim_seed);
        return int'(r % limit);
    endfunction

    function automatic logic [31:0] expected_status();
        return {exp_count, 7'd0, exp_new, exp_last};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Error: timeout waiting for %s", what);
        err_count++;
        hung = 1'b1;
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs) begin
            pass_count++;
            $display("Test %s: passed", name);
        end else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", name, err_count - test_errs);
        end
    endtask

    `include "tb_axil_tasks.svh"

    // Enable, stream, disable, then let the last beat reach status
    task automatic run_capture(input logic [31:0] ctrl_val, input int nbits);
        logic [31:0] exp;
        logic [31:0] got;
        axil_write({24'h0, ctrl_addr}, ctrl_val, 4'hf);
        repeat (nbits) @(negedge s_axi_aclk);
        axil_write({24'h0, ctrl_addr}, 32'h0, 4'hf);
        repeat (4) @(negedge s_axi_aclk);
        exp = expected_status();
        axil_read({24'h0, status_addr}, got);
        check_value("status", got, exp);
        check_value("new_byte", 32'(got[8]), 32'h1);
    endtask

    task automatic register_access();
        logic [31:0] got;
        logic [31:0] data;
        logic [3:0]  strb;
        start_test();
        axil_read({24'h0, ctrl_addr}, got);
        check_value("ctrl", got, 32'h0);
        axil_read({24'h0, status_addr}, got);
        check_value("status", got, 32'h0);
        data = $random(stim_seed);
        strb = 4'(pick_below(16));
        axil_write({24'h0, ctrl_addr}, data, strb);
        axil_read({24'h0, ctrl_addr}, got);
        check_value("ctrl", got, mirror_raw);
        axil_read(32'h0000_0010, got);  // Unmapped
        check_value("unmapped rdata", got, 32'h0);
        axil_write({24'h0, ctrl_addr}, 32'h0, 4'hf);
        end_test("register access");
    endtask

    task automatic ordered_capture(input logic msb, input string name);
        start_test();
        run_capture({30'h0, msb, 1'b1}, 4 + pick_below(73));  // 8 to 80 bits with write latency
        end_test(name);
    endtask

    task automatic sticky_flag();
        logic [31:0] exp;
        logic [31:0] got;
        start_test();
        exp = expected_status();
        axil_read({24'h0, status_addr}, got);
        check_value("status", got, exp);
        check_value("new_byte", 32'(got[8]), 32'h0);
        end_test("sticky new_byte");
    endtask

    task automatic flush_partial();
        start_test();
        axil_write({24'h0, ctrl_addr}, 32'h1, 4'hf);
        repeat (pick_below(4)) @(negedge s_axi_aclk);
        axil_write({24'h0, ctrl_addr}, 32'h0, 4'hf);
        axil_write({24'h0, ctrl_addr}, 32'h4, 4'h1);
        run_capture(32'h1, 4);  // Write latency adds four samples
        end_test("flush");
    endtask

    task automatic back_pressure();
        logic [31:0] got;
        start_test();
        bp_max = 6;
        run_capture(32'(1 + 2 * pick_below(2)), 8 + pick_below(73));
        axil_read({24'h0, ctrl_addr}, got);
        check_value("ctrl", got, mirror_raw);
        bp_max = 0;
        end_test("back-pressure");
    endtask

    initial begin
        s_axi_aresetn  = 1'b0;
        s_axi_awaddr   = 32'h0;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = 32'h0;
        s_axi_wstrb    = 4'h0;
        s_axi_wvalid   = 1'b0;
        s_axi_bready   = 1'b0;
        s_axi_araddr   = 32'h0;
        s_axi_arvalid  = 1'b0;
        s_axi_rready   = 1'b0;
        bp_max         = 0;
        err_count      = 0;
        pass_count     = 0;
        fail_count     = 0;
        hung           = 1'b0;
        pend_raw       = 32'h0;
        pend_flush     = 1'b0;
        rd_status_pend = 1'b0;
        repeat (4) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        register_access();
        if (!hung) ordered_capture(1'b0, "LSB-first capture");
        if (!hung) ordered_capture(1'b1, "MSB-first capture");
        if (!hung) sticky_flag();
        if (!hung) flush_partial();
        if (!hung) back_pressure();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
